/* design/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] strb_t;

	// RV32I major opcodes
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_op_reg,
		cls_illegal
	} op_class_e;

	typedef enum logic [4:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_byte,
		mem_half,
		mem_word
	} mem_size_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_exec,
		st_mem,
		st_write,
		st_trap
	} ctrl_state_e;

endpackage

/* design/rv_dec_if.sv */
interface rv_dec_if;
	rv_pkg::reg_idx_t rd;
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::word_t imm;
	rv_pkg::op_class_e op_class;
	rv_pkg::alu_op_e alu_op;
	rv_pkg::mem_size_e mem_size;
	logic mem_unsigned;

	modport dec (output rd, rs1, rs2, imm, op_class, alu_op, mem_size, mem_unsigned);
	modport user (input rd, rs1, rs2, imm, op_class, alu_op, mem_size, mem_unsigned);
endinterface

// handshake between the instruction FSM and the bus master
interface rv_lsu_if;
	logic fetch_start;
	logic data_start;
	rv_pkg::word_t pc;
	logic done;
	logic fault;             // qualified by done
	rv_pkg::word_t rdata;

	modport ctrl (output fetch_start, data_start, pc, input done, fault, rdata);
	modport lsu (input fetch_start, data_start, pc, output done, fault, rdata);
endinterface

/* design/rv_decoder.sv */
module rv_decoder (
	input  logic clk,
	input  rv_pkg::word_t instr,
	rv_dec_if.dec dec
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm_j;
	rv_pkg::word_t imm;
	rv_pkg::op_class_e op_class;
	rv_pkg::alu_op_e alu_op;
	rv_pkg::mem_size_e mem_size;
	logic use_rd;
	logic use_rs1;
	logic use_rs2;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		op_class = rv_pkg::cls_illegal;
		imm = '0;
		use_rd = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			rv_pkg::opc_lui: begin
				op_class = rv_pkg::cls_lui;
				imm = imm_u;
				use_rd = 1'b1;
			end
			rv_pkg::opc_auipc: begin
				op_class = rv_pkg::cls_auipc;
				imm = imm_u;
				use_rd = 1'b1;
			end
			rv_pkg::opc_jal: begin
				op_class = rv_pkg::cls_jal;
				imm = imm_j;
				use_rd = 1'b1;
			end
			rv_pkg::opc_jalr: begin
				if (funct3 == 3'b000) op_class = rv_pkg::cls_jalr;
				imm = imm_i;
				use_rd = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_pkg::opc_branch: begin
				if (funct3[2:1] != 2'b01) op_class = rv_pkg::cls_branch;
				imm = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_pkg::opc_load: begin
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) op_class = rv_pkg::cls_load;
				imm = imm_i;
				use_rd = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_pkg::opc_store: begin
				if (!funct3[2] && funct3[1:0] != 2'b11) op_class = rv_pkg::cls_store;
				imm = imm_s;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_pkg::opc_op_imm: begin
				if (!(funct3 == 3'b001 && funct7 != 7'd0) &&
					!(funct3 == 3'b101 && funct7 != 7'd0 && funct7 != 7'b0100000))
					op_class = rv_pkg::cls_op_imm;
				imm = imm_i;
				use_rd = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_pkg::opc_op: begin
				if (funct7 == 7'd0 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
					op_class = rv_pkg::cls_op_reg;
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000: alu_op = (opcode == rv_pkg::opc_op && funct7[5]) ? rv_pkg::alu_sub
				: rv_pkg::alu_add;
			3'b001: alu_op = rv_pkg::alu_sll;
			3'b010: alu_op = rv_pkg::alu_slt;
			3'b011: alu_op = rv_pkg::alu_sltu;
			3'b100: alu_op = rv_pkg::alu_xor;
			3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: alu_op = rv_pkg::alu_or;
			default: alu_op = rv_pkg::alu_and;
		endcase
		if (opcode == rv_pkg::opc_branch) begin
			case (funct3)
				3'b000: alu_op = rv_pkg::alu_eq;
				3'b001: alu_op = rv_pkg::alu_ne;
				3'b100: alu_op = rv_pkg::alu_lt;
				3'b101: alu_op = rv_pkg::alu_ge;
				3'b110: alu_op = rv_pkg::alu_ltu;
				default: alu_op = rv_pkg::alu_geu;
			endcase
		end else if (opcode != rv_pkg::opc_op_imm && opcode != rv_pkg::opc_op) begin
			alu_op = rv_pkg::alu_add;
		end
	end

	always_comb begin
		case (funct3[1:0])
			2'b00: mem_size = rv_pkg::mem_byte;
			2'b01: mem_size = rv_pkg::mem_half;
			default: mem_size = rv_pkg::mem_word;
		endcase
	end

	always_ff @(posedge clk) begin
		dec.rd <= use_rd ? instr[11:7] : '0;
		dec.rs1 <= use_rs1 ? instr[19:15] : '0;
		dec.rs2 <= use_rs2 ? instr[24:20] : '0;
		dec.imm <= imm;
		dec.op_class <= op_class;
		dec.alu_op <= alu_op;
		dec.mem_size <= mem_size;
		dec.mem_unsigned <= funct3[2];
	end
endmodule

/* design/rv_regfile.sv */
module rv_regfile (
	input  logic clk,
	input  logic rstn,
	input  rv_pkg::reg_idx_t rs1_idx,
	input  rv_pkg::reg_idx_t rs2_idx,
	input  rv_pkg::reg_idx_t rd_idx,
	input  logic we,
	input  rv_pkg::word_t wdata,
	output rv_pkg::word_t rs1_data,
	output rv_pkg::word_t rs2_data
);
	rv_pkg::word_t regs [1:31];    // x0 has no storage

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd_idx != '0) begin
			regs[rd_idx] <= wdata;
		end
	end
endmodule

/* design/rv_alu.sv */
module rv_alu (
	input  logic clk,
	input  logic rstn,
	rv_dec_if.user dec,
	input  rv_pkg::word_t src1,
	input  rv_pkg::word_t src2,
	output rv_pkg::word_t result
);
	rv_pkg::word_t opb;
	logic [4:0] shamt;

	// register operand for R-type and branches, immediate otherwise
	assign opb = (dec.op_class == rv_pkg::cls_op_reg || dec.op_class == rv_pkg::cls_branch)
		? src2 : dec.imm;
	assign shamt = opb[4:0];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			case (dec.alu_op)
				rv_pkg::alu_add: result <= src1 + opb;
				rv_pkg::alu_sub: result <= src1 - opb;
				rv_pkg::alu_sll: result <= src1 << shamt;
				rv_pkg::alu_slt: result <= {31'd0, $signed(src1) < $signed(opb)};
				rv_pkg::alu_sltu: result <= {31'd0, src1 < opb};
				rv_pkg::alu_xor: result <= src1 ^ opb;
				rv_pkg::alu_srl: result <= src1 >> shamt;
				rv_pkg::alu_sra: result <= $signed(src1) >>> shamt;
				rv_pkg::alu_or: result <= src1 | opb;
				rv_pkg::alu_and: result <= src1 & opb;
				rv_pkg::alu_eq: result <= {31'd0, src1 == opb};
				rv_pkg::alu_ne: result <= {31'd0, src1 != opb};
				rv_pkg::alu_lt: result <= {31'd0, $signed(src1) < $signed(opb)};
				rv_pkg::alu_ge: result <= {31'd0, $signed(src1) >= $signed(opb)};
				rv_pkg::alu_ltu: result <= {31'd0, src1 < opb};
				rv_pkg::alu_geu: result <= {31'd0, src1 >= opb};
				default: result <= '0;
			endcase
		end
	end
endmodule

/* design/rv_lsu.sv */
module rv_lsu (
	input  logic clk,
	input  logic rstn,
	rv_dec_if.user dec,
	rv_lsu_if.lsu ctl,
	input  rv_pkg::word_t src1,
	input  rv_pkg::word_t src2,
	output rv_pkg::word_t araddr,
	output logic arvalid,
	input  logic arready,
	input  rv_pkg::word_t rdata,
	input  logic rvalid,
	output logic rready,
	output rv_pkg::word_t awaddr,
	output logic awvalid,
	input  logic awready,
	output rv_pkg::word_t wdata,
	output rv_pkg::strb_t wstrb,
	output logic wvalid,
	input  logic wready,
	input  logic bvalid,
	output logic bready
);
	typedef enum logic [2:0] {ls_idle, ls_ar, ls_r, ls_w, ls_b} ls_state_e;

	ls_state_e state;
	rv_pkg::word_t addr;
	logic misaligned;
	logic is_fetch;
	rv_pkg::word_t ld_lane;
	rv_pkg::word_t ld_val;
	rv_pkg::word_t st_data;
	rv_pkg::strb_t st_strb;

	assign addr = src1 + dec.imm;
	assign misaligned = (dec.mem_size == rv_pkg::mem_half && addr[0]) ||
		(dec.mem_size == rv_pkg::mem_word && addr[1:0] != 2'b00);

	// big endian, offset 0 sits in bits 31:24
	assign ld_lane = rdata << {addr[1:0], 3'b000};

	always_comb begin
		case (dec.mem_size)
			rv_pkg::mem_byte: ld_val = dec.mem_unsigned ? {24'd0, ld_lane[31:24]}
				: {{24{ld_lane[31]}}, ld_lane[31:24]};
			rv_pkg::mem_half: ld_val = dec.mem_unsigned ? {16'd0, ld_lane[31:16]}
				: {{16{ld_lane[31]}}, ld_lane[31:16]};
			default: ld_val = rdata;
		endcase
	end

	always_comb begin
		case (dec.mem_size)
			rv_pkg::mem_byte: begin
				st_data = {src2[7:0], 24'd0} >> {addr[1:0], 3'b000};
				st_strb = 4'b1000 >> addr[1:0];
			end
			rv_pkg::mem_half: begin
				st_data = {src2[15:0], 16'd0} >> {addr[1:0], 3'b000};
				st_strb = 4'b1100 >> addr[1:0];
			end
			default: begin
				st_data = src2;
				st_strb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ls_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			ctl.done <= 1'b0;
			ctl.fault <= 1'b0;
		end else begin
			ctl.done <= 1'b0;
			case (state)
				ls_idle: begin
					if (ctl.fetch_start) begin
						arvalid <= 1'b1;
						state <= ls_ar;
					end else if (ctl.data_start) begin
						if (misaligned) begin
							ctl.done <= 1'b1;    // no bus transfer
							ctl.fault <= 1'b1;
						end else if (dec.op_class == rv_pkg::cls_store) begin
							awvalid <= 1'b1;
							wvalid <= 1'b1;
							state <= ls_w;
						end else begin
							arvalid <= 1'b1;
							state <= ls_ar;
						end
					end
				end
				ls_ar: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						state <= ls_r;
					end
				end
				ls_r: begin
					if (rvalid) begin
						rready <= 1'b0;
						ctl.done <= 1'b1;
						ctl.fault <= 1'b0;
						state <= ls_idle;
					end
				end
				ls_w: begin
					if (awready) awvalid <= 1'b0;
					if (wready) wvalid <= 1'b0;
					if ((awready || !awvalid) && (wready || !wvalid)) begin
						bready <= 1'b1;    // both channels accepted
						state <= ls_b;
					end
				end
				ls_b: begin
					if (bvalid) begin
						bready <= 1'b0;
						ctl.done <= 1'b1;
						ctl.fault <= 1'b0;
						state <= ls_idle;
					end
				end
				default: state <= ls_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ls_idle && ctl.fetch_start) begin
			araddr <= ctl.pc;
			is_fetch <= 1'b1;
		end else if (state == ls_idle && ctl.data_start) begin
			araddr <= {addr[31:2], 2'b00};
			awaddr <= {addr[31:2], 2'b00};
			wdata <= st_data;
			wstrb <= st_strb;
			is_fetch <= 1'b0;
		end
		if (state == ls_r && rvalid) begin
			ctl.rdata <= is_fetch ? rdata : ld_val;
		end
	end
endmodule

/* design/rv_control.sv */
module rv_control #(
	parameter rv_pkg::word_t reset_pc = 32'h0000_0000,
	parameter rv_pkg::word_t trap_addr = 32'h0000_0100
) (
	input  logic clk,
	input  logic rstn,
	rv_dec_if.user dec,
	rv_lsu_if.ctrl ctl,
	input  rv_pkg::word_t alu_result,
	input  rv_pkg::word_t rs1_data,
	input  rv_pkg::word_t imm,
	output rv_pkg::word_t instr,
	output logic rd_we,
	output rv_pkg::word_t wdata
);
	rv_pkg::ctrl_state_e state;
	rv_pkg::word_t pc;
	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t next_pc;
	logic is_mem;
	logic writes_rd;

	assign ctl.pc = pc;
	assign pc_plus4 = pc + 32'd4;
	assign is_mem = dec.op_class == rv_pkg::cls_load || dec.op_class == rv_pkg::cls_store;
	assign writes_rd = dec.op_class inside {rv_pkg::cls_lui, rv_pkg::cls_auipc,
		rv_pkg::cls_jal, rv_pkg::cls_jalr, rv_pkg::cls_load, rv_pkg::cls_op_imm,
		rv_pkg::cls_op_reg};
	assign rd_we = (state == rv_pkg::st_write) && writes_rd;

	always_comb begin
		case (dec.op_class)
			rv_pkg::cls_lui: wdata = imm;
			rv_pkg::cls_auipc: wdata = pc + imm;
			rv_pkg::cls_jal, rv_pkg::cls_jalr: wdata = pc_plus4;
			rv_pkg::cls_load: wdata = ctl.rdata;
			default: wdata = alu_result;
		endcase
	end

	always_comb begin
		case (dec.op_class)
			rv_pkg::cls_jalr: next_pc = (rs1_data + imm) & ~32'd1;
			rv_pkg::cls_jal: next_pc = pc + imm;
			rv_pkg::cls_branch: next_pc = alu_result[0] ? pc + imm : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= rv_pkg::st_fetch;
			pc <= reset_pc;
			ctl.fetch_start <= 1'b1;    // first fetch right out of reset
			ctl.data_start <= 1'b0;
		end else begin
			ctl.fetch_start <= 1'b0;
			ctl.data_start <= 1'b0;
			case (state)
				rv_pkg::st_fetch: begin
					if (ctl.done) state <= rv_pkg::st_decode;
				end
				rv_pkg::st_decode: state <= rv_pkg::st_exec;
				rv_pkg::st_exec: begin
					if (dec.op_class == rv_pkg::cls_illegal) begin
						state <= rv_pkg::st_trap;
					end else begin
						ctl.data_start <= is_mem;
						state <= rv_pkg::st_mem;
					end
				end
				rv_pkg::st_mem: begin
					if (!is_mem) begin
						state <= rv_pkg::st_write;
					end else if (ctl.done) begin
						state <= ctl.fault ? rv_pkg::st_trap : rv_pkg::st_write;
					end
				end
				rv_pkg::st_write: begin
					pc <= next_pc;
					ctl.fetch_start <= 1'b1;
					state <= rv_pkg::st_fetch;
				end
				rv_pkg::st_trap: begin
					pc <= trap_addr;
					ctl.fetch_start <= 1'b1;
					state <= rv_pkg::st_fetch;
				end
				default: state <= rv_pkg::st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == rv_pkg::st_fetch && ctl.done) begin
			instr <= ctl.rdata;
		end
	end
endmodule

/* design/rv_core.sv */
module rv_core #(
	parameter rv_pkg::word_t reset_pc = 32'h0000_0000,
	parameter rv_pkg::word_t trap_addr = 32'h0000_0100
) (
	input  logic clk,
	input  logic rstn,
	output rv_pkg::word_t araddr,
	output logic arvalid,
	input  logic arready,
	input  rv_pkg::word_t rdata,
	input  logic rvalid,
	output logic rready,
	output rv_pkg::word_t awaddr,
	output logic awvalid,
	input  logic awready,
	output rv_pkg::word_t wdata,
	output rv_pkg::strb_t wstrb,
	output logic wvalid,
	input  logic wready,
	input  logic bvalid,
	output logic bready
);
	rv_pkg::word_t instr;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;
	rv_pkg::word_t alu_result;
	rv_pkg::word_t rd_wdata;
	logic rd_we;

	rv_dec_if dec_bus ();
	rv_lsu_if lsu_bus ();

	rv_decoder decoder_i (.clk(clk), .instr(instr), .dec(dec_bus));

	rv_regfile regfile_i (
		.clk(clk), .rstn(rstn),
		.rs1_idx(dec_bus.rs1), .rs2_idx(dec_bus.rs2), .rd_idx(dec_bus.rd),
		.we(rd_we), .wdata(rd_wdata),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_alu alu_i (
		.clk(clk), .rstn(rstn), .dec(dec_bus),
		.src1(rs1_data), .src2(rs2_data), .result(alu_result)
	);

	rv_lsu lsu_i (
		.clk(clk), .rstn(rstn), .dec(dec_bus), .ctl(lsu_bus),
		.src1(rs1_data), .src2(rs2_data),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	rv_control #(.reset_pc(reset_pc), .trap_addr(trap_addr)) control_i (
		.clk(clk), .rstn(rstn), .dec(dec_bus), .ctl(lsu_bus),
		.alu_result(alu_result), .rs1_data(rs1_data), .imm(dec_bus.imm),
		.instr(instr), .rd_we(rd_we), .wdata(rd_wdata)
	);
endmodule

/* verification/tb_mem.sv */
module tb_mem #(
	parameter int mem_words = 256
) (
	input  logic clk,
	input  logic rstn,
	input  logic delay_en,
	input  rv_pkg::word_t image [mem_words],
	input  rv_pkg::word_t araddr,
	input  logic arvalid,
	output logic arready,
	output rv_pkg::word_t rdata,
	output logic rvalid,
	input  logic rready,
	input  rv_pkg::word_t awaddr,
	input  logic awvalid,
	output logic awready,
	input  rv_pkg::word_t wdata,
	input  rv_pkg::strb_t wstrb,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready
);
	rv_pkg::word_t mem [mem_words];    // big endian words
	rv_pkg::word_t rd_log [$];
	rv_pkg::word_t wr_addr_log [$];
	rv_pkg::word_t wr_data_log [$];
	rv_pkg::strb_t wr_strb_log [$];
	logic [31:0] lfsr = 32'h3431_ce05;
	logic mem_rstn = 1'b0;
	logic ar_rdy = 1'b0;
	logic r_vld = 1'b0;
	logic aw_rdy = 1'b0;
	logic w_rdy = 1'b0;
	logic b_vld = 1'b0;
	rv_pkg::word_t r_data = '0;
	rv_pkg::word_t r_addr;
	rv_pkg::word_t w_addr;
	rv_pkg::word_t w_data;
	rv_pkg::strb_t w_strb;
	logic r_busy;
	logic aw_done;
	logic w_done;
	int ar_cnt;
	int r_cnt;
	int aw_cnt;
	int w_cnt;
	int b_cnt;

	assign arready = ar_rdy;
	assign rvalid = r_vld;
	assign rdata = r_data;
	assign awready = aw_rdy;
	assign wready = w_rdy;
	assign bvalid = b_vld;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// 0 to 3 idle cycles, two lfsr bits
	function automatic int draw_delay();
		int d;
		d = 0;
		if (delay_en) begin
			for (int i = 0; i < 2; i++) begin
				d = (d << 1) | int'(lfsr[0]);
				lfsr = lfsr_step(lfsr);
			end
		end
		return d;
	endfunction

	always @(posedge clk) mem_rstn <= rstn;

	always @(negedge clk) begin
		if (!mem_rstn) begin
			for (int i = 0; i < mem_words; i++) mem[i] = image[i];
			ar_rdy = 1'b0;
			r_vld = 1'b0;
			aw_rdy = 1'b0;
			w_rdy = 1'b0;
			b_vld = 1'b0;
			r_busy = 1'b0;
			aw_done = 1'b0;
			w_done = 1'b0;
			ar_cnt = 0;
			r_cnt = 0;
			aw_cnt = 0;
			w_cnt = 0;
			b_cnt = 0;
			rd_log.delete();
			wr_addr_log.delete();
			wr_data_log.delete();
			wr_strb_log.delete();
		end else begin
			if (ar_rdy) ar_rdy = 1'b0;    // handshake taken at the last posedge
			else if (arvalid && !r_busy) begin
				if (ar_cnt == 0) begin
					ar_rdy = 1'b1;
					r_addr = araddr;
					rd_log.push_back(araddr);
					r_busy = 1'b1;
					ar_cnt = draw_delay();
				end else ar_cnt--;
			end
			if (r_vld) begin
				r_vld = 1'b0;
				r_busy = 1'b0;
			end else if (r_busy && rready) begin
				if (r_cnt == 0) begin
					r_vld = 1'b1;
					r_data = mem[r_addr[9:2]];
					r_cnt = draw_delay();
				end else r_cnt--;
			end
			if (aw_rdy) aw_rdy = 1'b0;
			else if (awvalid && !aw_done) begin
				if (aw_cnt == 0) begin
					aw_rdy = 1'b1;
					w_addr = awaddr;
					aw_done = 1'b1;
					aw_cnt = draw_delay();
				end else aw_cnt--;
			end
			if (w_rdy) w_rdy = 1'b0;
			else if (wvalid && !w_done) begin
				if (w_cnt == 0) begin
					w_rdy = 1'b1;
					w_data = wdata;
					w_strb = wstrb;
					w_done = 1'b1;
					w_cnt = draw_delay();
				end else w_cnt--;
			end
			if (b_vld) b_vld = 1'b0;
			else if (aw_done && w_done && bready) begin
				if (b_cnt == 0) begin
					for (int i = 0; i < 4; i++) begin
						if (w_strb[i]) mem[w_addr[9:2]][8 * i +: 8] = w_data[8 * i +: 8];
					end
					wr_addr_log.push_back(w_addr);
					wr_data_log.push_back(w_data);
					wr_strb_log.push_back(w_strb);
					b_vld = 1'b1;
					aw_done = 1'b0;
					w_done = 1'b0;
					b_cnt = draw_delay();
				end else b_cnt--;
			end
		end
	end
endmodule

/* verification/tb_core.sv */
module tb_core;
	localparam int mem_words = 256;
	localparam rv_pkg::word_t trap_addr = 32'h0000_0100;
	localparam rv_pkg::word_t data_base = 32'h0000_0200;

	logic clk;
	logic rstn;
	logic delay_en;
	rv_pkg::word_t araddr;
	logic arvalid;
	logic arready;
	rv_pkg::word_t rdata;
	logic rvalid;
	logic rready;
	rv_pkg::word_t awaddr;
	logic awvalid;
	logic awready;
	rv_pkg::word_t wdata;
	rv_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	rv_pkg::word_t image [mem_words];
	rv_pkg::word_t xv [32];    // register values the program sets up
	rv_pkg::word_t exp_addr [$];
	rv_pkg::word_t exp_data [$];
	rv_pkg::strb_t exp_strb [$];
	rv_pkg::word_t prog_ptr;
	int st_off;

	rv_core #(.reset_pc(32'h0000_0000), .trap_addr(trap_addr)) dut_i (
		.clk(clk), .rstn(rstn),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	tb_mem #(.mem_words(mem_words)) tb_mem_i (
		.clk(clk), .rstn(rstn), .delay_en(delay_en), .image(image),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	always #4 clk = ~clk;

	function automatic rv_pkg::word_t enc_r(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::opc_op};
	endfunction

	function automatic rv_pkg::word_t enc_i(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic rv_pkg::word_t enc_s(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::opc_store};
	endfunction

	function automatic rv_pkg::word_t enc_b(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			rv_pkg::opc_branch};
	endfunction

	function automatic rv_pkg::word_t enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic rv_pkg::word_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::opc_jal};
	endfunction

	// RV32I OP and OP-IMM result where alt is instr bit 30
	function automatic rv_pkg::word_t alu_ref(input int f3, input logic alt,
		input rv_pkg::word_t a, input rv_pkg::word_t b);
		case (f3)
			0: return alt ? a - b : a + b;
			1: return a << b[4:0];
			2: return {31'd0, $signed(a) < $signed(b)};
			3: return {31'd0, a < b};
			4: return a ^ b;
			5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input int f3, input rv_pkg::word_t a,
		input rv_pkg::word_t b);
		case (f3)
			0: return a == b;
			1: return a != b;
			4: return $signed(a) < $signed(b);
			5: return $signed(a) >= $signed(b);
			6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic rv_pkg::word_t strb_mask(input rv_pkg::strb_t s);
		rv_pkg::word_t m;
		for (int i = 0; i < 4; i++) m[8 * i +: 8] = {8{s[i]}};
		return m;
	endfunction

	task automatic fail_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_word(input string what, input rv_pkg::word_t got,
		input rv_pkg::word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic compare_strb(input string what, input rv_pkg::strb_t got,
		input rv_pkg::strb_t exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic emit(input rv_pkg::word_t w);
		image[prog_ptr[9:2]] = w;
		prog_ptr += 32'd4;
	endtask

	task automatic load_imm(input int rd, input rv_pkg::word_t value);
		rv_pkg::word_t upper;
		upper = value + 32'h800;
		emit(enc_u(int'(upper[31:12]), rd, rv_pkg::opc_lui));
		emit(enc_i(int'(value[11:0]), rd, 0, rd, rv_pkg::opc_op_imm));
		xv[rd] = value;
	endtask

	task automatic new_program();
		for (int i = 0; i < mem_words; i++) image[i] = 32'hA5C3_0000 ^ (32'(i) << 2);
		image[trap_addr[9:2]] = enc_j(0, 0);    // trap handler spins
		for (int i = 0; i < 32; i++) xv[i] = '0;
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
		prog_ptr = '0;
		st_off = 0;
		load_imm(10, data_base);
	endtask

	task automatic expect_write(input rv_pkg::word_t a, input rv_pkg::word_t d,
		input rv_pkg::strb_t s);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_strb.push_back(s);
	endtask

	task automatic emit_sw(input int rs2, output rv_pkg::word_t a);
		a = data_base + 32'(st_off);
		emit(enc_s(st_off, rs2, 10, 2));
		st_off += 4;
	endtask

	// release reset and wait for the fetch of halt
	task automatic run_program(input rv_pkg::word_t halt);
		int limit;
		int cycles;
		limit = 40 * int'(prog_ptr >> 2) + 200;
		cycles = 0;
		@(negedge clk);
		rstn = 1'b0;
		repeat (2) @(negedge clk);
		rstn = 1'b1;
		while (!(tb_mem_i.rd_log.size() > 0 && tb_mem_i.rd_log[$] == halt)) begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("timeout: no fetch from %h within %0d cycles", halt, limit);
				fail_run();
			end
		end
	endtask

	task automatic check_writes();
		if (tb_mem_i.wr_addr_log.size() != exp_addr.size()) begin
			$display("wrong number of bus writes: %0d seen, %0d expected",
				tb_mem_i.wr_addr_log.size(), exp_addr.size());
			fail_run();
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			compare_word("store address", tb_mem_i.wr_addr_log[i], exp_addr[i]);
			compare_word("store data",
				tb_mem_i.wr_data_log[i] & strb_mask(tb_mem_i.wr_strb_log[i]), exp_data[i]);
			compare_strb("store strobe", tb_mem_i.wr_strb_log[i], exp_strb[i]);
		end
	endtask

	task automatic check_trap(input rv_pkg::word_t fault_pc);
		int idx;
		idx = -1;
		for (int i = 0; i < tb_mem_i.rd_log.size(); i++) begin
			if (idx < 0 && tb_mem_i.rd_log[i] == fault_pc) idx = i;
		end
		if (idx < 0 || idx + 1 >= tb_mem_i.rd_log.size()) begin
			$display("faulting instruction at %h was never fetched", fault_pc);
			fail_run();
		end
		compare_word("read after trap", tb_mem_i.rd_log[idx + 1], trap_addr);
		check_writes();
	endtask

	task automatic alu_reg(input int f3, input int f7, input int rs1, input int rs2);
		rv_pkg::word_t a;
		emit(enc_r(f7, rs2, rs1, f3, 4));
		emit_sw(4, a);
		expect_write(a, alu_ref(f3, f7[5], xv[rs1], xv[rs2]), 4'b1111);
	endtask

	task automatic alu_imm(input int f3, input int imm, input int rs1);
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		b = {{20{imm[11]}}, imm[11:0]};
		emit(enc_i(imm, rs1, f3, 4, rv_pkg::opc_op_imm));
		emit_sw(4, a);
		expect_write(a, alu_ref(f3, f3 == 5 && imm[10], xv[rs1], b), 4'b1111);
	endtask

	task automatic test_alu();
		new_program();
		load_imm(1, 32'h1234_5678);
		load_imm(2, 32'hFFFF_FFF9);
		load_imm(3, 32'd5);
		alu_reg(0, 0, 1, 2);
		alu_reg(0, 32, 1, 2);
		alu_reg(1, 0, 1, 3);
		alu_reg(2, 0, 2, 1);
		alu_reg(3, 0, 2, 1);
		alu_reg(4, 0, 1, 2);
		alu_reg(5, 0, 2, 3);
		alu_reg(5, 32, 2, 3);
		alu_reg(6, 0, 1, 2);
		alu_reg(7, 0, 1, 2);
		alu_imm(0, -100, 1);
		alu_imm(2, -3, 2);
		alu_imm(3, 5, 2);
		alu_imm(4, 12'h5a5, 1);
		alu_imm(6, 12'h0f0, 1);
		alu_imm(7, 12'hf0f, 2);
		alu_imm(1, 7, 1);
		alu_imm(5, 9, 2);
		alu_imm(5, 12'h409, 2);    // srai
		emit(enc_j(0, 0));
		run_program(prog_ptr - 32'd4);
		check_writes();
	endtask

	task automatic test_stores();
		rv_pkg::word_t d;
		rv_pkg::strb_t s;
		new_program();
		load_imm(5, 32'hA1B2_C3D4);
		for (int k = 0; k < 4; k++) begin
			d = '0;
			s = '0;
			d[31 - 8 * k -: 8] = 8'hD4;    // offset 0 is the top byte lane
			s[3 - k] = 1'b1;
			emit(enc_s(k, 5, 10, 0));
			expect_write(data_base, d, s);
		end
		emit(enc_s(0, 5, 10, 1));
		expect_write(data_base, 32'hC3D4_0000, 4'b1100);
		emit(enc_s(2, 5, 10, 1));
		expect_write(data_base, 32'h0000_C3D4, 4'b0011);
		emit(enc_j(0, 0));
		run_program(prog_ptr - 32'd4);
		check_writes();
	endtask

	task automatic test_loads();
		rv_pkg::word_t src;
		rv_pkg::word_t a;
		logic [7:0] b;
		logic [15:0] h;
		new_program();
		src = 32'h80F1_7F42;
		image[data_base[9:2]] = src;
		st_off = 64;    // results land past the source word
		for (int u = 0; u < 2; u++) begin
			for (int k = 0; k < 4; k++) begin
				b = 8'(src >> (24 - 8 * k));
				emit(enc_i(k, 10, 4 * u, 6, rv_pkg::opc_load));
				emit_sw(6, a);
				expect_write(a, u == 1 ? {24'd0, b} : {{24{b[7]}}, b}, 4'b1111);
			end
			for (int k = 0; k < 4; k += 2) begin
				h = 16'(src >> (16 - 8 * k));
				emit(enc_i(k, 10, 4 * u + 1, 6, rv_pkg::opc_load));
				emit_sw(6, a);
				expect_write(a, u == 1 ? {16'd0, h} : {{16{h[15]}}, h}, 4'b1111);
			end
		end
		emit(enc_j(0, 0));
		run_program(prog_ptr - 32'd4);
		check_writes();
	endtask

	task automatic branch_case(input int f3, input int rs1, input int rs2);
		rv_pkg::word_t a;
		emit(enc_b(8, rs2, rs1, f3));
		emit_sw(8, a);    // only on the fall-through path
		if (!branch_taken(f3, xv[rs1], xv[rs2])) expect_write(a, xv[8], 4'b1111);
		emit_sw(7, a);
		expect_write(a, xv[7], 4'b1111);
	endtask

	task automatic test_control();
		rv_pkg::word_t a;
		rv_pkg::word_t at;
		new_program();
		load_imm(1, 32'd5);
		load_imm(2, 32'hFFFF_FFFD);
		load_imm(7, 32'h55);
		load_imm(8, 32'hBAD);
		branch_case(0, 1, 1);
		branch_case(0, 1, 2);
		branch_case(1, 1, 2);
		branch_case(1, 1, 1);
		branch_case(4, 2, 1);
		branch_case(4, 1, 2);
		branch_case(5, 1, 2);
		branch_case(5, 2, 1);
		branch_case(6, 1, 2);
		branch_case(6, 2, 1);
		branch_case(7, 2, 1);
		branch_case(7, 1, 2);
		at = prog_ptr;
		emit(enc_j(8, 9));
		emit_sw(8, a);
		emit_sw(9, a);
		expect_write(a, at + 32'd4, 4'b1111);
		at = prog_ptr;
		emit(enc_i(int'(at) + 12, 0, 0, 12, rv_pkg::opc_op_imm));
		emit(enc_i(0, 12, 0, 13, rv_pkg::opc_jalr));
		emit_sw(8, a);
		emit_sw(13, a);
		expect_write(a, at + 32'd8, 4'b1111);
		emit(enc_j(0, 0));
		run_program(prog_ptr - 32'd4);
		check_writes();
	endtask

	task automatic test_traps();
		rv_pkg::word_t at;
		rv_pkg::word_t a;
		new_program();
		at = prog_ptr;
		emit(32'hFFFF_FFFF);
		emit_sw(10, a);
		run_program(trap_addr);
		check_trap(at);
		new_program();
		at = prog_ptr;
		emit(enc_i(2, 10, 2, 6, rv_pkg::opc_load));    // misaligned lw
		emit_sw(6, a);
		run_program(trap_addr);
		check_trap(at);
	endtask

	task automatic run_all_tests();
		test_alu();
		test_stores();
		test_loads();
		test_control();
		test_traps();
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		delay_en = 1'b0;
		run_all_tests();
		delay_en = 1'b1;    // same programs under back-pressure
		run_all_tests();
		$display("TESTBENCH PASSED");
		$finish;
	end
endmodule

/* project.f */
design/rv_pkg.sv
design/rv_dec_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_control.sv
design/rv_core.sv
verification/tb_mem.sv
verification/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_core
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= project.f

SRCS := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
